/* axis_upsizer.f */
rtl/axis_upsizer_pkg.sv
rtl/word_stream_if.sv
rtl/byte_packer.sv
rtl/word_fifo.sv
rtl/axis_upsizer.sv
tests/axis_upsizer_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the upsizer testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module axis_upsizer_tb \
  -f axis_upsizer.f -Mdir obj_dir -o axis_upsizer_sim || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/axis_upsizer_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "All checks passed" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* tests/axis_upsizer_tb.sv */
// upsizer testbench with clock and reset, lfsr, expected word queue, checker and directed tests
`timescale 1ns/1ps
`default_nettype none

module axis_upsizer_tb;

  import axis_upsizer_pkg::*;

  // cycles allowed for any single wait
  localparam int wait_limit = 200;

  logic   s_axis_aclk;
  logic   s_axis_arstn;
  byte_t  s_axis_tdata;
  tid_t   s_axis_tid;
  tdest_t s_axis_tdest;
  logic   s_axis_tvalid;
  logic   s_axis_tlast;
  logic   s_axis_tready;
  word_t  m_axis_tdata;
  tid_t   m_axis_tid;
  tdest_t m_axis_tdest;
  logic   m_axis_tvalid;
  logic   m_axis_tlast;
  logic   m_axis_tready;

  logic [31:0] lfsr_state;
  // expected words with the oldest first
  word_t  exp_data[$];
  tid_t   exp_tid[$];
  tdest_t exp_tdest[$];
  logic   exp_last[$];
  // accepted bytes of the word in progress
  byte_t  pend_bytes[upsize_ratio];
  int     pend_count;
  int     words_seen;

  axis_upsizer u_dut (
    .s_axis_aclk   (s_axis_aclk),
    .s_axis_arstn  (s_axis_arstn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tid    (s_axis_tid),
    .s_axis_tdest  (s_axis_tdest),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tid    (m_axis_tid),
    .m_axis_tdest  (m_axis_tdest),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready)
  );

  // 20 ns clock
  initial begin
    s_axis_aclk = 1'b0;
    forever #10 s_axis_aclk = ~s_axis_aclk;
  end

  // --------------------
  // helpers

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  task automatic stop_on_error(string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      stop_on_error("value mismatch");
    end
  endtask

  // reference model puts the first byte in the top lane and takes the sideband from the fourth
  task automatic record_byte(byte_t data, tid_t tid, tdest_t tdest, logic last);
    word_t w;
    pend_bytes[pend_count] = data;
    pend_count++;
    if (pend_count == upsize_ratio) begin
      w = '0;
      for (int i = 0; i < upsize_ratio; i++) begin
        w = {w[word_w-byte_w-1:0], pend_bytes[i]};
      end
      exp_data.push_back(w);
      exp_tid.push_back(tid);
      exp_tdest.push_back(tdest);
      exp_last.push_back(last);
      pend_count = 0;
    end
  endtask

  // output monitor
  // a transfer seen here completes at the next rising edge
  always @(negedge s_axis_aclk) begin : receive_words
    if (s_axis_arstn === 1'b1 && m_axis_tvalid === 1'b1 && m_axis_tready === 1'b1) begin
      if (exp_data.size() == 0) begin
        stop_on_error("m_axis delivered a word that was never sent");
      end else begin
        check_value("m_axis_tdata", m_axis_tdata, exp_data.pop_front());
        check_value("m_axis_tid", m_axis_tid, exp_tid.pop_front());
        check_value("m_axis_tdest", m_axis_tdest, exp_tdest.pop_front());
        check_value("m_axis_tlast", m_axis_tlast, exp_last.pop_front());
        words_seen++;
      end
    end
  end

  // --------------------
  // drivers

  task automatic send_byte(byte_t data, tid_t tid, tdest_t tdest, logic last);
    int waited;
    waited = 0;
    s_axis_tdata  = data;
    s_axis_tid    = tid;
    s_axis_tdest  = tdest;
    s_axis_tlast  = last;
    s_axis_tvalid = 1'b1;
    @(negedge s_axis_aclk);
    while (s_axis_tready !== 1'b1) begin
      waited++;
      if (waited > wait_limit) begin
        stop_on_error("byte never accepted, s_axis_tready stayed low");
      end
      @(negedge s_axis_aclk);
    end
    record_byte(data, tid, tdest, last);
    @(posedge s_axis_aclk);
    #2;
    s_axis_tvalid = 1'b0;
  endtask

  task automatic hold_reset(int cycles);
    s_axis_arstn  = 1'b0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    // an unfinished word is dropped by the reset
    pend_count = 0;
    repeat (cycles) begin
      @(negedge s_axis_aclk);
      check_value("s_axis_tready", s_axis_tready, 0);
    end
    @(posedge s_axis_aclk);
    #2;
    s_axis_arstn = 1'b1;
    @(negedge s_axis_aclk);
    check_value("m_axis_tvalid", m_axis_tvalid, 0);
    @(posedge s_axis_aclk);
    #2;
  endtask

  task automatic wait_words(int target);
    int waited;
    waited = 0;
    while (words_seen < target) begin
      if (waited == wait_limit) begin
        stop_on_error($sformatf("only %0d of %0d words came out", words_seen, target));
      end
      @(posedge s_axis_aclk);
      #2;
      waited++;
    end
  endtask

  // after some quiet cycles nothing extra may have come out
  task automatic expect_no_more(int total);
    repeat (8) begin
      @(posedge s_axis_aclk);
      #2;
    end
    check_value("words received", words_seen, total);
    check_value("words pending", exp_data.size(), 0);
  endtask

  // --------------------
  // tests

  task automatic reset_recovery();
    int base;
    hold_reset(5);
    m_axis_tready = 1'b1;
    base = words_seen;
    send_byte(8'hde, 8'h01, 8'h02, 1'b0);
    send_byte(8'had, 8'h01, 8'h02, 1'b0);
    hold_reset(5);
    send_byte(8'h01, 8'h00, 8'h00, 1'b0);
    send_byte(8'h02, 8'h00, 8'h00, 1'b0);
    send_byte(8'h03, 8'h00, 8'h00, 1'b0);
    send_byte(8'h04, 8'h31, 8'h32, 1'b1);
    wait_words(base + 1);
    expect_no_more(base + 1);
  endtask

  task automatic pack_single_word();
    int base;
    base = words_seen;
    m_axis_tready = 1'b1;
    send_byte(8'h11, 8'h00, 8'h00, 1'b0);
    send_byte(8'h22, 8'h00, 8'h00, 1'b0);
    send_byte(8'h33, 8'h00, 8'h00, 1'b0);
    send_byte(8'h44, 8'h5a, 8'ha5, 1'b1);
    // with an empty fifo the word shows after the second edge past the fourth byte
    @(negedge s_axis_aclk);
    check_value("m_axis_tvalid", m_axis_tvalid, 0);
    @(negedge s_axis_aclk);
    check_value("m_axis_tvalid", m_axis_tvalid, 0);
    @(negedge s_axis_aclk);
    check_value("m_axis_tvalid", m_axis_tvalid, 1);
    check_value("m_axis_tdata", m_axis_tdata, 32'h11223344);
    @(posedge s_axis_aclk);
    #2;
    wait_words(base + 1);
  endtask

  task automatic split_packet();
    int base;
    base = words_seen;
    m_axis_tready = 1'b1;
    for (int i = 0; i < 12; i++) begin
      send_byte(byte_t'(8'ha0 + i), tid_t'(8'h10 + i), tdest_t'(8'h20 + i), i == 11);
    end
    wait_words(base + 3);
  endtask

  task automatic random_flow();
    int base;
    int sent;
    int cycles;
    logic presenting;
    base = words_seen;
    sent = 0;
    cycles = 0;
    presenting = 1'b0;
    while (sent < 64) begin
      m_axis_tready = lfsr_bit();
      // about one cycle in four stays idle
      if (!presenting && rand_bits(2) != 0) begin
        s_axis_tdata  = byte_t'(rand_bits(8));
        s_axis_tid    = tid_t'(rand_bits(8));
        s_axis_tdest  = tdest_t'(rand_bits(8));
        s_axis_tlast  = (sent % 16 == 15);
        s_axis_tvalid = 1'b1;
        presenting = 1'b1;
      end
      @(negedge s_axis_aclk);
      if (presenting && s_axis_tready === 1'b1) begin
        record_byte(s_axis_tdata, s_axis_tid, s_axis_tdest, s_axis_tlast);
        sent++;
        presenting = 1'b0;
      end
      @(posedge s_axis_aclk);
      #2;
      if (!presenting) s_axis_tvalid = 1'b0;
      cycles++;
      if (cycles > 4 * wait_limit) begin
        stop_on_error("random byte stream did not finish in time");
      end
    end
    m_axis_tready = 1'b1;
    wait_words(base + 16);
  endtask

  task automatic stall_and_drain();
    int base;
    int offered;
    logic stalled;
    base = words_seen;
    offered = 0;
    stalled = 1'b0;
    m_axis_tready = 1'b0;
    while (!stalled) begin
      if (offered == 80) begin
        stop_on_error("s_axis_tready never dropped while m_axis_tready was low");
      end
      s_axis_tdata  = byte_t'(8'h80 + offered);
      s_axis_tid    = tid_t'(offered / 4);
      s_axis_tdest  = tdest_t'(~(offered / 4));
      s_axis_tlast  = (offered % 8 == 7);
      s_axis_tvalid = 1'b1;
      @(negedge s_axis_aclk);
      if (s_axis_tready === 1'b1) begin
        record_byte(s_axis_tdata, s_axis_tid, s_axis_tdest, s_axis_tlast);
        offered++;
      end else begin
        stalled = 1'b1;
      end
      @(posedge s_axis_aclk);
      #2;
    end
    // 16 fifo words and the slot word fill up before s_axis_tready drops
    check_value("bytes accepted", offered, 17 * upsize_ratio);
    // the oldest word waits at the fifo head
    check_value("m_axis_tvalid", m_axis_tvalid, 1);
    check_value("m_axis_tdata", m_axis_tdata, exp_data[0]);
    m_axis_tready = 1'b1;
    for (int i = offered; i < 80; i++) begin
      send_byte(byte_t'(8'h80 + i), tid_t'(i / 4), tdest_t'(~(i / 4)), i % 8 == 7);
    end
    wait_words(base + 20);
    expect_no_more(base + 20);
  endtask

  // --------------------
  // main sequence

  initial begin
    s_axis_arstn  = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tid    = '0;
    s_axis_tdest  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b0;
    lfsr_state    = 32'hc567dec1;
    pend_count    = 0;
    words_seen    = 0;
    reset_recovery();
    pack_single_word();
    split_packet();
    random_flow();
    stall_and_drain();
    if (exp_data.size() == 0 && pend_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      stop_on_error("some expected words never came out");
    end
  end

endmodule

`default_nettype wire

/* rtl/axis_upsizer.sv */
// axi stream 8 to 32 bit upsizer top: byte packer, word interface and word fifo
`timescale 1ns/1ps
`default_nettype none

module axis_upsizer (
  input  logic                     s_axis_aclk,
  input  logic                     s_axis_arstn,

  // --------------------
  // byte stream in

  // payload, first byte of a word ends in bits 31:24
  input  axis_upsizer_pkg::byte_t  s_axis_tdata,
  // sideband, taken from the fourth byte of each word
  input  axis_upsizer_pkg::tid_t   s_axis_tid,
  input  axis_upsizer_pkg::tdest_t s_axis_tdest,
  input  logic                     s_axis_tvalid,
  // only legal on the fourth byte of a word
  input  logic                     s_axis_tlast,
  output logic                     s_axis_tready,

  // --------------------
  // word stream out

  output axis_upsizer_pkg::word_t  m_axis_tdata,
  output axis_upsizer_pkg::tid_t   m_axis_tid,
  output axis_upsizer_pkg::tdest_t m_axis_tdest,
  output logic                     m_axis_tvalid,
  output logic                     m_axis_tlast,
  input  logic                     m_axis_tready
);

  // packer to fifo word link
  word_stream_if u_words ();

  // stage 1, four bytes into one word slot
  byte_packer u_packer (
    .s_axis_aclk   (s_axis_aclk),
    .s_axis_arstn  (s_axis_arstn),
    .byte_in_data  (s_axis_tdata),
    .byte_in_tid   (s_axis_tid),
    .byte_in_tdest (s_axis_tdest),
    .byte_in_valid (s_axis_tvalid),
    .byte_in_last  (s_axis_tlast),
    .byte_in_ready (s_axis_tready),
    .words         (u_words.src)
  );

  // stage 2, buffering so input keeps flowing while the output stalls
  word_fifo #(
    .depth (axis_upsizer_pkg::fifo_depth)
  ) u_fifo (
    .s_axis_aclk   (s_axis_aclk),
    .s_axis_arstn  (s_axis_arstn),
    .words         (u_words.snk),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tid    (m_axis_tid),
    .m_axis_tdest  (m_axis_tdest),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

endmodule

`default_nettype wire

/* rtl/word_fifo.sv */
// stage 2 word fifo: circular buffer of words with sideband, head drives the m_axis outputs
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
  parameter int depth = axis_upsizer_pkg::fifo_depth
) (
  input  logic                     s_axis_aclk,
  input  logic                     s_axis_arstn,
  // words from the packer
  word_stream_if.snk               words,
  // axi stream master side
  output axis_upsizer_pkg::word_t  m_axis_tdata,
  output axis_upsizer_pkg::tid_t   m_axis_tid,
  output axis_upsizer_pkg::tdest_t m_axis_tdest,
  output logic                     m_axis_tlast,
  output logic                     m_axis_tvalid,
  input  logic                     m_axis_tready
);

  import axis_upsizer_pkg::*;

  // --------------------
  // storage

  word_t  mem_data  [depth];
  tid_t   mem_tid   [depth];
  tdest_t mem_tdest [depth];
  logic   mem_last  [depth];

  // --------------------
  // control

  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  // entries held, 0 to depth
  logic [fifo_ptr_w:0]   count;
  // an entry was written at the last edge and is not yet at the head
  logic                  fresh_write;
  logic                  full;
  logic                  wr_en;
  logic                  pop;

  assign full  = (count == (fifo_ptr_w + 1)'(depth));
  assign wr_en = words.tvalid && !full;
  assign pop   = m_axis_tvalid && m_axis_tready;

  // back-pressure to the packer
  assign words.tready = !full;

  // write side, payload only
  always_ff @(posedge s_axis_aclk) begin
    if (wr_en) begin
      mem_data[wr_ptr]  <= words.tdata;
      mem_tid[wr_ptr]   <= words.tid;
      mem_tdest[wr_ptr] <= words.tdest;
      mem_last[wr_ptr]  <= words.tlast;
    end
  end

  // pointers wrap at depth-1 so any depth up to 2**fifo_ptr_w works
  always_ff @(posedge s_axis_aclk) begin
    if (!s_axis_arstn) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      fresh_write <= 1'b0;
    end else begin
      fresh_write <= wr_en;
      if (wr_en) begin
        wr_ptr <= (wr_ptr == fifo_ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == fifo_ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // write and pop together leave the count alone
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------
  // head of the queue

  // the newest entry shows one cycle after its write
  // any older entry is already visible
  assign m_axis_tvalid = (count > {{fifo_ptr_w{1'b0}}, fresh_write});
  assign m_axis_tdata  = mem_data[rd_ptr];
  assign m_axis_tid    = mem_tid[rd_ptr];
  assign m_axis_tdest  = mem_tdest[rd_ptr];
  assign m_axis_tlast  = mem_last[rd_ptr];

  // --------------------
  // checks

  // a full fifo takes no word at the next edge
  a_no_write_full : assert property (
    @(posedge s_axis_aclk) disable iff (!s_axis_arstn)
    full |=> $stable(wr_ptr)
  ) else $error("word_fifo: write while full");

  // an empty fifo is never popped
  a_no_pop_empty : assert property (
    @(posedge s_axis_aclk) disable iff (!s_axis_arstn)
    (count == '0) |=> $stable(rd_ptr)
  ) else $error("word_fifo: pop while empty");

  a_count_range : assert property (
    @(posedge s_axis_aclk) disable iff (!s_axis_arstn)
    count <= (fifo_ptr_w + 1)'(depth)
  ) else $error("word_fifo: occupancy above depth");

endmodule

`default_nettype wire

/* rtl/byte_packer.sv */
// stage 1 byte packer: lane counter, lane register and output word slot with handshake
`timescale 1ns/1ps
`default_nettype none

module byte_packer (
  input  logic                     s_axis_aclk,
  input  logic                     s_axis_arstn,
  // byte stream in
  input  axis_upsizer_pkg::byte_t  byte_in_data,
  input  axis_upsizer_pkg::tid_t   byte_in_tid,
  input  axis_upsizer_pkg::tdest_t byte_in_tdest,
  input  logic                     byte_in_valid,
  input  logic                     byte_in_last,
  output logic                     byte_in_ready,
  // finished words out
  word_stream_if.src               words
);

  import axis_upsizer_pkg::*;

  // --------------------
  // lane tracking

  // lane that the next accepted byte goes to
  lane_idx_t lane_idx;
  // next byte completes the word
  logic      last_lane;
  // byte handshake this cycle
  logic      byte_fire;
  // first three bytes of the word in progress, oldest byte on top
  logic [word_w-byte_w-1:0] lane_reg;

  // --------------------
  // output slot

  slot_state_e slot_state;
  word_t       slot_data;
  tid_t        slot_tid;
  tdest_t      slot_tdest;
  logic        slot_last;
  // fifo takes the slot word this cycle
  logic        slot_take;

  assign last_lane = (lane_idx == '0);
  assign byte_fire = byte_in_valid && byte_in_ready;
  assign slot_take = words.tvalid && words.tready;

  // accept while the slot is free or being drained in this cycle
  // held low during reset
  assign byte_in_ready = s_axis_arstn && ((slot_state == slot_empty) || words.tready);

  // lane counter, counts down from the msb lane and wraps on the fourth byte
  always_ff @(posedge s_axis_aclk) begin
    if (!s_axis_arstn) begin
      lane_idx <= lane_idx_t'(upsize_ratio - 1);
    end else if (byte_fire) begin
      if (last_lane) begin
        lane_idx <= lane_idx_t'(upsize_ratio - 1);
      end else begin
        lane_idx <= lane_idx - 1'b1;
      end
    end
  end

  // shift the early bytes up so the first one ends at the top
  // after a reset the stale bytes fall out before the next word completes
  always_ff @(posedge s_axis_aclk) begin
    if (byte_fire && !last_lane) begin
      lane_reg <= {lane_reg[word_w-2*byte_w-1:0], byte_in_data};
    end
  end

  // slot state
  // a new word may land in the same cycle the old one leaves
  always_ff @(posedge s_axis_aclk) begin
    if (!s_axis_arstn) begin
      slot_state <= slot_empty;
    end else if (byte_fire && last_lane) begin
      slot_state <= slot_full;
    end else if (slot_take) begin
      slot_state <= slot_empty;
    end
  end

  // slot payload, sideband comes from the fourth byte
  always_ff @(posedge s_axis_aclk) begin
    if (byte_fire && last_lane) begin
      slot_data  <= {lane_reg, byte_in_data};
      slot_tid   <= byte_in_tid;
      slot_tdest <= byte_in_tdest;
      slot_last  <= byte_in_last;
    end
  end

  // --------------------
  // word stream out

  assign words.tvalid = (slot_state == slot_full);
  assign words.tdata  = slot_data;
  assign words.tid    = slot_tid;
  assign words.tdest  = slot_tdest;
  assign words.tlast  = slot_last;

  // --------------------
  // checks

  // packets must end on a word boundary
  a_last_in_final_lane : assert property (
    @(posedge s_axis_aclk) disable iff (!s_axis_arstn)
    (byte_fire && byte_in_last) |-> last_lane
  ) else $error("byte_packer: tlast accepted outside the final lane");

  // a word refused by the fifo must not change before it is taken
  a_slot_stable : assert property (
    @(posedge s_axis_aclk) disable iff (!s_axis_arstn)
    (words.tvalid && !words.tready) |=>
      (words.tvalid && $stable(words.tdata) && $stable(words.tid) &&
       $stable(words.tdest) && $stable(words.tlast))
  ) else $error("byte_packer: slot word changed while waiting");

endmodule

`default_nettype wire

/* rtl/word_stream_if.sv */
// word stream interface: one 32-bit word with tid, tdest, tlast and valid/ready handshake
`timescale 1ns/1ps
`default_nettype none

interface word_stream_if;

  import axis_upsizer_pkg::*;

  // payload and sideband
  word_t  tdata;
  tid_t   tid;
  tdest_t tdest;
  logic   tlast;
  // handshake, a word moves when both are high at the edge
  logic   tvalid;
  logic   tready;

  // word producer, fields held stable while tvalid waits for tready
  modport src (
    output tdata, tid, tdest, tlast, tvalid,
    input  tready
  );

  // word consumer
  modport snk (
    input  tdata, tid, tdest, tlast, tvalid,
    output tready
  );

endinterface

`default_nettype wire

/* rtl/axis_upsizer_pkg.sv */
// upsizer package: stream widths, packing ratio, fifo depth, vector types, slot state enum
`default_nettype none

package axis_upsizer_pkg;

  // --------------------
  // widths and ratio

  // input beat width
  localparam int byte_w = 8;
  // output beat width
  localparam int word_w = 32;
  // input beats per output beat
  localparam int upsize_ratio = 4;
  // enough bits to count upsize_ratio lanes
  localparam int lane_idx_w = 2;

  // --------------------
  // word fifo sizing

  localparam int fifo_depth = 16;
  // pointer must address every entry
  localparam int fifo_ptr_w = 4;

  // --------------------
  // vector types

  typedef logic [byte_w-1:0] byte_t;
  typedef logic [word_w-1:0] word_t;
  // stream identifier and routing destination
  typedef logic [7:0] tid_t;
  typedef logic [7:0] tdest_t;
  // lane counter, upsize_ratio-1 is the msb lane
  typedef logic [lane_idx_w-1:0] lane_idx_t;

  // packer output slot, holds one finished word
  typedef enum logic {
    slot_empty = 1'b0,
    slot_full  = 1'b1
  } slot_state_e;

endpackage

`default_nettype wire
